//--- design/boardPkg.sv
package boardPkg;

    // Nexys A7 on-board oscillator.
    localparam int clkMhz = 100;

    // Board I/O widths.
    localparam int keyWidth   = 5;
    localparam int swWidth    = 16;
    localparam int ledWidth   = 16;
    localparam int digitCount = 8;

    // Bit position of each push button inside the key vector.
    typedef enum int unsigned {
        keyRight  = 0,
        keyCenter = 1,
        keyLeft   = 2,
        keyUp     = 3,
        keyDown   = 4
    } keyIndex;

endpackage

//--- design/displayPkg.sv
package displayPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Timing constants.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int debounceCycles = 256;
    localparam int scanCycles     = 64;

    // A 25 MHz pixel rate is derived from the board clock.
    localparam int pixelDivide = boardPkg::clkMhz / 25;

    localparam int hVisible = 640;
    localparam int hFront   = 16;
    localparam int hSync    = 96;
    localparam int hBack    = 48;
    localparam int hTotal   = hVisible + hFront + hSync + hBack;

    localparam int vVisible = 480;
    localparam int vFront   = 10;
    localparam int vSync    = 2;
    localparam int vBack    = 33;
    localparam int vTotal   = vVisible + vFront + vSync + vBack;

    localparam int barCount = 8;
    localparam int barWidth = hVisible / barCount;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        opNone, opAdd, opSub, opClear, opShiftLeft, opShiftRight
    } accOp;

    // Segment a sits in the MSB; all bits are active high inside the lab.
    typedef struct packed {
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic f;
        logic g;
        logic dp;
    } segPattern;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } vgaOut;

endpackage

//--- design/keyConditioner.sv
`timescale 1ns/1ps

module keyConditioner
    import boardPkg::*, displayPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [keyWidth-1:0] key,
    output logic [keyWidth-1:0] press
);

    localparam int countWidth = $clog2(debounceCycles);

    logic [keyWidth-1:0]   syncFirst;
    logic [keyWidth-1:0]   syncSecond;
    logic [keyWidth-1:0]   level;
    logic [keyWidth-1:0]   levelPrev;
    logic [countWidth-1:0] stableCount [keyWidth];

    // Two flops per button bring the raw levels into the clock domain.
    always_ff @(posedge clk) begin
        if (rst) begin
            syncFirst  <= '0;
            syncSecond <= '0;
        end else begin
            syncFirst  <= key;
            syncSecond <= syncFirst;
        end
    end

    // A new level is taken only after it has differed from the accepted one
    // for debounceCycles clocks in a row. Any return to the old level
    // restarts the count.
    always_ff @(posedge clk) begin
        if (rst) begin
            level <= '0;
            for (int i = 0; i < keyWidth; i++) begin
                stableCount[i] <= '0;
            end
        end else begin
            for (int i = 0; i < keyWidth; i++) begin
                if (syncSecond[i] == level[i]) begin
                    stableCount[i] <= '0;
                end else if (stableCount[i] == countWidth'(debounceCycles - 1)) begin
                    level[i]       <= syncSecond[i];
                    stableCount[i] <= '0;
                end else begin
                    stableCount[i] <= stableCount[i] + 1'b1;
                end
            end
        end
    end

    // One-cycle pulse on each rising accepted level.
    always_ff @(posedge clk) begin
        if (rst) begin
            levelPrev <= '0;
            press     <= '0;
        end else begin
            levelPrev <= level;
            press     <= level & ~levelPrev;
        end
    end

endmodule

//--- design/accumulatorUnit.sv
`timescale 1ns/1ps

module accumulatorUnit
    import boardPkg::*, displayPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [keyWidth-1:0] press,
    input  logic [swWidth-1:0]  operand,
    output logic [31:0]         acc
);

    accOp        op;
    logic [31:0] operandExt;

    assign operandExt = 32'(operand);

    // Clear wins over everything, then add, sub and the two shifts.
    always_comb begin
        op = opNone;
        if (press[keyCenter]) begin
            op = opClear;
        end else if (press[keyRight]) begin
            op = opAdd;
        end else if (press[keyLeft]) begin
            op = opSub;
        end else if (press[keyUp]) begin
            op = opShiftLeft;
        end else if (press[keyDown]) begin
            op = opShiftRight;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else begin
            case (op)
                opAdd:        acc <= acc + operandExt;
                opSub:        acc <= acc - operandExt;
                opClear:      acc <= '0;
                opShiftLeft:  acc <= {acc[27:0], operand[3:0]};
                opShiftRight: acc <= {4'h0, acc[31:4]};
                default:      acc <= acc;
            endcase
        end
    end

endmodule

//--- design/sevenSegScanner.sv
`timescale 1ns/1ps

module sevenSegScanner
    import boardPkg::*, displayPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           value,
    output segPattern             segments,
    output logic [digitCount-1:0] digit
);

    localparam int scanWidth = $clog2(scanCycles);
    localparam int posWidth  = $clog2(digitCount);

    logic [scanWidth-1:0] scanCount;
    logic [posWidth-1:0]  position;

    // Hex font, segments a to g, decimal point off.
    function automatic segPattern hexToSeg(input logic [3:0] nibble);
        logic [6:0] abcdefg;
        case (nibble)
            4'h0:    abcdefg = 7'b1111110;
            4'h1:    abcdefg = 7'b0110000;
            4'h2:    abcdefg = 7'b1101101;
            4'h3:    abcdefg = 7'b1111001;
            4'h4:    abcdefg = 7'b0110011;
            4'h5:    abcdefg = 7'b1011011;
            4'h6:    abcdefg = 7'b1011111;
            4'h7:    abcdefg = 7'b1110000;
            4'h8:    abcdefg = 7'b1111111;
            4'h9:    abcdefg = 7'b1111011;
            4'ha:    abcdefg = 7'b1110111;
            4'hb:    abcdefg = 7'b0011111;
            4'hc:    abcdefg = 7'b1001110;
            4'hd:    abcdefg = 7'b0111101;
            4'he:    abcdefg = 7'b1001111;
            default: abcdefg = 7'b1000111;
        endcase
        return segPattern'({abcdefg, 1'b0});
    endfunction

    // Position 0 is the least significant nibble.
    always_ff @(posedge clk) begin
        if (rst) begin
            scanCount <= '0;
            position  <= '0;
        end else begin
            scanCount <= scanCount + 1'b1;
            if (scanCount == scanWidth'(scanCycles - 1)) begin
                position <= position + 1'b1;
            end
        end
    end

    // Digit enable and pattern come out of the same edge, so they stay aligned.
    always_ff @(posedge clk) begin
        if (rst) begin
            digit    <= digitCount'(1);
            segments <= '0;
        end else begin
            digit    <= digitCount'(1) << position;
            segments <= hexToSeg(value[position * 4 +: 4]);
        end
    end

endmodule

//--- design/vgaBarGenerator.sv
`timescale 1ns/1ps

module vgaBarGenerator
    import displayPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] value,
    output vgaOut       vga
);

    localparam int divWidth = $clog2(pixelDivide);
    localparam int hWidth   = $clog2(hTotal);
    localparam int vWidth   = $clog2(vTotal);
    localparam int barBits  = $clog2(barCount);

    logic [divWidth-1:0] divCount;
    logic                pixelEn;
    logic [hWidth-1:0]   hCount;
    logic [vWidth-1:0]   vCount;
    logic                visible;
    logic                hsyncActive;
    logic                vsyncActive;
    logic [barBits-1:0]  barIndex;
    logic [3:0]          nibble;

    assign pixelEn = (divCount == divWidth'(pixelDivide - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster counters.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            divCount <= '0;
            hCount   <= '0;
            vCount   <= '0;
        end else begin
            divCount <= pixelEn ? '0 : divCount + 1'b1;
            if (pixelEn) begin
                if (hCount == hWidth'(hTotal - 1)) begin
                    hCount <= '0;
                    vCount <= (vCount == vWidth'(vTotal - 1)) ? '0 : vCount + 1'b1;
                end else begin
                    hCount <= hCount + 1'b1;
                end
            end
        end
    end

    assign visible     = (hCount < hWidth'(hVisible)) && (vCount < vWidth'(vVisible));
    assign hsyncActive = (hCount >= hWidth'(hVisible + hFront))
                      && (hCount <  hWidth'(hVisible + hFront + hSync));
    assign vsyncActive = (vCount >= vWidth'(vVisible + vFront))
                      && (vCount <  vWidth'(vVisible + vFront + vSync));

    // Only meaningful inside the visible columns.
    assign barIndex = barBits'(hCount / barWidth);
    assign nibble   = value[barIndex * 4 +: 4];

    // Sync pulses are active low.
    always_ff @(posedge clk) begin
        if (rst) begin
            vga <= '{hsync: 1'b1, vsync: 1'b1, default: '0};
        end else begin
            vga.hsync <= ~hsyncActive;
            vga.vsync <= ~vsyncActive;
            vga.red   <= visible ? nibble  : 4'h0;
            vga.green <= visible ? ~nibble : 4'h0;
            vga.blue  <= 4'h0;
        end
    end

endmodule

//--- design/labTop.sv
`timescale 1ns/1ps

module labTop
    import boardPkg::*, displayPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [keyWidth-1:0]   key,
    input  logic [swWidth-1:0]    sw,
    output logic [ledWidth-1:0]   led,
    output segPattern             segments,
    output logic [digitCount-1:0] digit,
    output vgaOut                 vga
);

    logic [keyWidth-1:0] press;
    logic [31:0]         acc;

    keyConditioner keyConditioner0 (
        .clk   (clk),
        .rst   (rst),
        .key   (key),
        .press (press)
    );

    accumulatorUnit accumulatorUnit0 (
        .clk     (clk),
        .rst     (rst),
        .press   (press),
        .operand (sw),
        .acc     (acc)
    );

    sevenSegScanner sevenSegScanner0 (
        .clk      (clk),
        .rst      (rst),
        .value    (acc),
        .segments (segments),
        .digit    (digit)
    );

    vgaBarGenerator vgaBarGenerator0 (
        .clk   (clk),
        .rst   (rst),
        .value (acc),
        .vga   (vga)
    );

    // Switch mirror.
    always_ff @(posedge clk) begin
        led <= sw;
    end

endmodule

//--- design/boardTop.sv
`timescale 1ns/1ps

module boardTop
    import boardPkg::*, displayPkg::*;
(
    input  logic                clk,
    input  logic                btnCpuReset,
    input  logic                btnC,
    input  logic                btnU,
    input  logic                btnL,
    input  logic                btnR,
    input  logic                btnD,
    input  logic [swWidth-1:0]  sw,
    output logic [ledWidth-1:0] led,
    output logic [6:0]          seg,
    output logic                dp,
    output logic [7:0]          an,
    output logic                Hsync,
    output logic                Vsync,
    output logic [3:0]          vgaRed,
    output logic [3:0]          vgaGreen,
    output logic [3:0]          vgaBlue,
    output logic                RGB1_Red,
    output logic                RGB1_Green,
    output logic                RGB1_Blue,
    output logic                RGB2_Red,
    output logic                RGB2_Green,
    output logic                RGB2_Blue,
    output logic                micClk,
    input  logic                micData,
    output logic                micLRSel,
    output logic                ampPWM,
    output logic                ampSD,
    input  logic                RsRx,
    inout  wire  [7:0]          JA,
    inout  wire  [7:0]          JB,
    inout  wire  [7:0]          JC,
    inout  wire  [7:0]          JD
);

    logic                  rst;
    logic [keyWidth-1:0]   key;
    segPattern             segments;
    logic [digitCount-1:0] digit;
    vgaOut                 vga;

    // The CPU reset button is active low.
    assign rst = ~btnCpuReset;

    assign key[keyRight]  = btnR;
    assign key[keyCenter] = btnC;
    assign key[keyLeft]   = btnL;
    assign key[keyUp]     = btnU;
    assign key[keyDown]   = btnD;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Unused peripherals held inactive.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign {RGB1_Red, RGB1_Green, RGB1_Blue} = 3'b000;
    assign {RGB2_Red, RGB2_Green, RGB2_Blue} = 3'b000;
    assign micClk   = 1'b0;
    assign micLRSel = 1'b0;
    assign ampPWM   = 1'b0;
    assign ampSD    = 1'b0;

    // Cathodes and anodes on the board are active low; seg[0] is segment a.
    assign seg[0] = ~segments.a;
    assign seg[1] = ~segments.b;
    assign seg[2] = ~segments.c;
    assign seg[3] = ~segments.d;
    assign seg[4] = ~segments.e;
    assign seg[5] = ~segments.f;
    assign seg[6] = ~segments.g;
    assign dp     = ~segments.dp;
    assign an     = ~digit;

    assign Hsync    = vga.hsync;
    assign Vsync    = vga.vsync;
    assign vgaRed   = vga.red;
    assign vgaGreen = vga.green;
    assign vgaBlue  = vga.blue;

    labTop labTop0 (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .sw       (sw),
        .led      (led),
        .segments (segments),
        .digit    (digit),
        .vga      (vga)
    );

endmodule

//--- verification/labTop_asserts.sv
`timescale 1ns/1ps

module labTopAsserts
    import boardPkg::*, displayPkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic [keyWidth-1:0]   press,
    input logic [31:0]           acc,
    input logic [digitCount-1:0] digit,
    input vgaOut                 vga
);

    // Exactly one digit is lit, and the lit position steps one place at a time.
    digitOneHot: assert property (@(posedge clk) disable iff (rst)
        $onehot(digit) && (digit == $past(digit)
            || digit == $past({digit[digitCount-2:0], digit[digitCount-1]})))
        else $error("digit enable is not one-hot or skipped a position");

    // No key produces a press in two consecutive cycles.
    pressSingleCycle: assert property (@(posedge clk) disable iff (rst)
        (press & $past(press)) == '0)
        else $error("press pulse lasted longer than one cycle");

    // The accumulator only moves on the edge after a press pulse.
    accHoldsWithoutPress: assert property (@(posedge clk) disable iff (rst)
        ($past(press) == '0) |-> $stable(acc))
        else $error("acc changed without a press pulse");

    // The horizontal sync pulse lies in the blanking interval.
    blankDuringHsync: assert property (@(posedge clk) disable iff (rst)
        !vga.hsync |-> (vga.red == 4'h0 && vga.green == 4'h0 && vga.blue == 4'h0))
        else $error("colour output is not blank while hsync is low");

endmodule

bind labTop labTopAsserts labTopAsserts0 (
    .clk   (clk),
    .rst   (rst),
    .press (press),
    .acc   (acc),
    .digit (digit),
    .vga   (vga)
);

//--- verification/boardTopTb.sv
`timescale 1ns/1ps

module boardTopTb
    import boardPkg::*, displayPkg::*;
();

    localparam int resetCycles = 16;
    localparam int holdCycles  = debounceCycles + 20;
    localparam int scanPeriod  = scanCycles * digitCount;
    localparam int lineCycles  = hTotal * pixelDivide;
    localparam int lineLimit   = 2 * lineCycles;
    localparam int frameLimit  = (vTotal + 1) * lineCycles;

    // Active-high gfedcba patterns of the hex digits 0 to F.
    localparam logic [6:0] hexFont [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic                clk;
    logic                btnCpuReset;
    logic [keyWidth-1:0] keys;
    logic [swWidth-1:0]  sw;
    logic                micData;
    logic                RsRx;
    logic [ledWidth-1:0] led;
    logic [6:0]          seg;
    logic                dp;
    logic [7:0]          an;
    logic                Hsync;
    logic                Vsync;
    logic [3:0]          vgaRed;
    logic [3:0]          vgaGreen;
    logic [3:0]          vgaBlue;
    wire  [2:0]          rgb1;
    wire  [2:0]          rgb2;
    wire                 micClk;
    wire                 micLRSel;
    wire                 ampPWM;
    wire                 ampSD;
    wire  [7:0]          pmodA;
    wire  [7:0]          pmodB;
    wire  [7:0]          pmodC;
    wire  [7:0]          pmodD;
    logic [31:0]         lfsrState;
    logic [31:0]         accModel;
    logic [31:0]         shown;
    logic [15:0]         operand;
    logic [3:0]          nib;
    int                  errorCount;
    int                  lowCycles;
    int                  highCycles;
    int                  elapsed;
    int                  target;

    always #50 clk = ~clk;

    boardTop dut0 (
        .clk         (clk),
        .btnCpuReset (btnCpuReset),
        .btnC        (keys[keyCenter]),
        .btnU        (keys[keyUp]),
        .btnL        (keys[keyLeft]),
        .btnR        (keys[keyRight]),
        .btnD        (keys[keyDown]),
        .sw          (sw),
        .led         (led),
        .seg         (seg),
        .dp          (dp),
        .an          (an),
        .Hsync       (Hsync),
        .Vsync       (Vsync),
        .vgaRed      (vgaRed),
        .vgaGreen    (vgaGreen),
        .vgaBlue     (vgaBlue),
        .RGB1_Red    (rgb1[2]),
        .RGB1_Green  (rgb1[1]),
        .RGB1_Blue   (rgb1[0]),
        .RGB2_Red    (rgb2[2]),
        .RGB2_Green  (rgb2[1]),
        .RGB2_Blue   (rgb2[0]),
        .micClk      (micClk),
        .micData     (micData),
        .micLRSel    (micLRSel),
        .ampPWM      (ampPWM),
        .ampSD       (ampSD),
        .RsRx        (RsRx),
        .JA          (pmodA),
        .JB          (pmodB),
        .JC          (pmodC),
        .JD          (pmodD)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random numbers, reporting and display decoding.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            reportFailure($sformatf("FAILED %s: expected %h, actual %h",
                                    testName, expected, actual));
        end
    endtask

    // Bit 4 flags a valid hex digit; seg is active low with seg[0] as segment a.
    function automatic logic [4:0] decodeDigit(input logic [6:0] segLow);
        for (int i = 0; i < 16; i++) begin
            if (hexFont[i] == ~segLow) begin
                return {1'b1, 4'(i)};
            end
        end
        return 5'h00;
    endfunction

    // Lets the scanner catch up, then assembles all eight digits over one scan period.
    task automatic readDisplay(output logic [31:0] value);
        logic [digitCount-1:0] seen;
        logic [4:0]            decoded;
        int                    pos;
        value = '0;
        seen  = '0;
        repeat (scanPeriod) @(posedge clk);
        for (int c = 0; c < scanPeriod; c++) begin
            @(negedge clk);
            if (!$onehot(~an)) begin
                reportFailure($sformatf("Anode lines %b do not select one digit.", an));
            end
            decoded = decodeDigit(seg);
            if (!decoded[4] || dp !== 1'b1) begin
                reportFailure($sformatf("Segment lines %b with dp %b are no hex digit.",
                                        seg, dp));
            end
            pos = 0;
            for (int d = 0; d < digitCount; d++) begin
                if (!an[d]) begin
                    pos = d;
                end
            end
            value[pos * 4 +: 4] = decoded[3:0];
            seen[pos] = 1'b1;
        end
        if (seen != '1) begin
            reportFailure("Not every digit position was lit within one scan period.");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and waits.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic pressKey(input keyIndex which, input logic [15:0] value);
        @(posedge clk);
        sw          <= value;
        keys[which] <= 1'b1;
        repeat (holdCycles) @(posedge clk);
        keys[which] <= 1'b0;
        repeat (holdCycles) @(posedge clk);
    endtask

    task automatic glitchKey(input keyIndex which, input int highTime, input int lowTime,
                             input int pulses);
        @(posedge clk);
        for (int p = 0; p < pulses; p++) begin
            keys[which] <= 1'b1;
            repeat (highTime) @(posedge clk);
            keys[which] <= 1'b0;
            repeat (lowTime) @(posedge clk);
        end
    endtask

    // Counts cycles up to and including the first one where the sync line has the level.
    task automatic waitSync(input bit vertical, input logic level, input int limit,
                            output int cycles);
        logic sample;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            sample = vertical ? Vsync : Hsync;
            if (Hsync === 1'b0 && {vgaRed, vgaGreen, vgaBlue} !== 12'h000) begin
                reportFailure("Colour outputs are not zero while Hsync is low.");
            end
            if (cycles > limit) begin
                reportFailure($sformatf("Timed out waiting for %s to become %b.",
                                        vertical ? "Vsync" : "Hsync", level));
            end
        end while (sample !== level);
    endtask

    initial begin
        clk         = 1'b0;
        lfsrState   = 32'h497b413d;
        accModel    = '0;
        errorCount  = 0;
        btnCpuReset = 1'b0;
        keys        = '0;
        sw          = '0;
        micData     = 1'b0;
        RsRx        = 1'b0;

        // Reset state is checked while the reset button is still held.
        @(posedge clk);
        sw <= 16'(takeBits(swWidth));
        repeat (resetCycles - 2) @(posedge clk);
        @(negedge clk);
        checkValue("reset led", {16'h0, sw}, {16'h0, led});
        checkValue("reset Hsync", 32'd1, {31'h0, Hsync});
        checkValue("reset Vsync", 32'd1, {31'h0, Vsync});
        checkValue("reset colour", 32'h0, {20'h0, vgaRed, vgaGreen, vgaBlue});
        checkValue("unused outputs", 32'h0,
                   {22'h0, rgb1, rgb2, micClk, micLRSel, ampPWM, ampSD});
        @(posedge clk);
        btnCpuReset <= 1'b1;
        readDisplay(shown);
        checkValue("reset display", accModel, shown);

        for (int n = 0; n < 12; n++) begin
            operand = 16'(takeBits(swWidth));
            if (takeBits(1) == 32'h0) begin
                pressKey(keyRight, operand);
                accModel = accModel + {16'h0, operand};
            end else begin
                pressKey(keyLeft, operand);
                accModel = accModel - {16'h0, operand};
            end
            readDisplay(shown);
            checkValue($sformatf("add/sub step %0d", n), accModel, shown);
            checkValue("led mirror", {16'h0, operand}, {16'h0, led});
        end

        // Two random bits pick up, down or centre; up is the more likely.
        for (int n = 0; n < 10; n++) begin
            operand = 16'(takeBits(swWidth));
            case (takeBits(2))
                32'd1: begin
                    pressKey(keyDown, operand);
                    accModel = {4'h0, accModel[31:4]};
                end
                32'd2: begin
                    pressKey(keyCenter, operand);
                    accModel = '0;
                end
                default: begin
                    pressKey(keyUp, operand);
                    accModel = {accModel[27:0], operand[3:0]};
                end
            endcase
            readDisplay(shown);
            checkValue($sformatf("shift/clear step %0d", n), accModel, shown);
        end

        @(posedge clk);
        sw <= 16'(takeBits(swWidth)) | 16'h0001;
        glitchKey(keyRight, debounceCycles / 2, holdCycles, 1);
        readDisplay(shown);
        checkValue("short pulse", accModel, shown);
        glitchKey(keyRight, debounceCycles - 40, 3, 4);
        readDisplay(shown);
        checkValue("bouncing key", accModel, shown);

        // Line timing, starting at a falling Hsync edge.
        waitSync(1'b0, 1'b1, lineLimit, lowCycles);
        waitSync(1'b0, 1'b0, lineLimit, lowCycles);
        for (int l = 0; l < 3; l++) begin
            waitSync(1'b0, 1'b1, lineLimit, lowCycles);
            waitSync(1'b0, 1'b0, lineLimit, highCycles);
            checkValue("Hsync low time", hSync * pixelDivide, lowCycles);
            checkValue("Hsync period", lineCycles, lowCycles + highCycles);
        end

        // Frame start, then the back porch lines, then a few visible lines in.
        waitSync(1'b1, 1'b0, frameLimit, lowCycles);
        waitSync(1'b1, 1'b1, frameLimit, lowCycles);
        for (int r = 0; r < vBack + 10; r++) begin
            waitSync(1'b0, 1'b0, lineLimit, lowCycles);
            waitSync(1'b0, 1'b1, lineLimit, highCycles);
        end
        elapsed = 0;
        for (int i = 0; i < barCount; i++) begin
            target = (hBack + barWidth * i + barWidth / 2) * pixelDivide;
            while (elapsed < target) begin
                @(negedge clk);
                elapsed++;
            end
            nib = accModel[i * 4 +: 4];
            checkValue($sformatf("bar %0d red", i), {28'h0, nib}, {28'h0, vgaRed});
            checkValue($sformatf("bar %0d green", i), {28'h0, ~nib}, {28'h0, vgaGreen});
            checkValue($sformatf("bar %0d blue", i), 32'h0, {28'h0, vgaBlue});
        end

        if (errorCount == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            reportFailure("Errors were recorded during the run.");
        end
    end

endmodule

//--- sources.f
design/boardPkg.sv
design/displayPkg.sv
design/keyConditioner.sv
design/accumulatorUnit.sv
design/sevenSegScanner.sv
design/vgaBarGenerator.sv
design/labTop.sv
design/boardTop.sv
verification/labTop_asserts.sv
verification/boardTopTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= boardTopTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= >>> FAIL
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
